/* source/sram_pkg.sv */
// Macro geometry widths and the address and data word typedefs
package sram_pkg;

  // Geometry of one single-port macro
  // 2048 words deep
  localparam int MACRO_ADDR_W = 11;
  // 128-bit data word
  localparam int DATA_W = 128;

  // Derived depth of one macro
  localparam int MACRO_DEPTH = 2 ** MACRO_ADDR_W;

  // Word address inside one macro
  typedef logic [MACRO_ADDR_W-1:0] sram_addr_t;

  // Data word and per-bit write mask share this type
  // Mask bits are active low as on the ASIC macro
  typedef logic [DATA_W-1:0] sram_data_t;

  // Only the top mask bit decides a write on the FPGA model
  localparam int WEN_CTRL_BIT = DATA_W - 1;

endpackage : sram_pkg

/* source/bank_pkg.sv */
// Config register map, config data types and the controller state enum
package bank_pkg;

  // Config bus widths
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 16;

  // Register index on the config bus
  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

  // Register data on the config bus
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;

  // Register map
  // Per-macro enable mask, one bit per macro
  localparam cfg_addr_t CFG_ENABLE = 2'd0;
  // Saturating drop counter, any write clears it
  localparam cfg_addr_t CFG_DROPS = 2'd1;
  // Write bit 0 to start init, read bit 0 for busy
  localparam cfg_addr_t CFG_INIT = 2'd2;

  // Controller states
  typedef enum logic [0:0] {
    IDLE = 1'b0,
    INIT = 1'b1
  } ctrl_state_t;

endpackage : bank_pkg

/* source/fpga_ram.sv */
// Behavioural single-port RAM with synchronous write and registered read
module fpga_ram #(
  parameter int DATA_W = 128,
  parameter int ADDR_W = 11
) (
  input  logic              CLK,
  input  logic [ADDR_W-1:0] port_addr,
  input  logic [DATA_W-1:0] port_din,
  input  logic              port_we,
  output logic [DATA_W-1:0] port_dout
);

  // Storage array
  logic [DATA_W-1:0] mem [2**ADDR_W];

  // Write port
  always_ff @(posedge CLK) begin
    if (port_we) begin
      mem[port_addr] <= port_din;
    end
  end

  // Read register loads every edge
  // Read-before-write, so a write cycle shows the old word
  always_ff @(posedge CLK) begin
    port_dout <= mem[port_addr];
  end

endmodule : fpga_ram

/* source/spsram_2048x128.sv */
// Macro wrapper with active-low controls, address holding and the RAM instance
module spsram_2048x128 (
  input  logic                 CLK,
  input  sram_pkg::sram_addr_t a,
  input  logic                 cen_n,
  input  logic                 gwen_n,
  input  sram_pkg::sram_data_t wen_n,
  input  sram_pkg::sram_data_t d,
  output sram_pkg::sram_data_t q
);

  import sram_pkg::*;

  sram_addr_t addr_hold;
  sram_addr_t ram_addr;
  logic       ram_we;

  // Write needs chip enable, global write and the top mask bit all low
  // Lower mask bits are ignored on the FPGA, whole-word writes only
  assign ram_we = !cen_n && !gwen_n && !wen_n[WEN_CTRL_BIT];

  // Capture the last address seen while enabled
  always_ff @(posedge CLK) begin
    if (!cen_n) begin
      addr_hold <= a;
    end
  end

  // Disabled macro keeps reading the held address
  // Keeps q stable between accesses
  assign ram_addr = cen_n ? addr_hold : a;

  fpga_ram #(
    .DATA_W(DATA_W),
    .ADDR_W(MACRO_ADDR_W)
  ) i_ram (
    .CLK      (CLK),
    .port_addr(ram_addr),
    .port_din (d),
    .port_we  (ram_we),
    .port_dout(q)
  );

  // Enabled macro must see a clean address
  // A floating address would corrupt the held read too
  a_addr_known: assert property (
    @(posedge CLK) !cen_n |-> !$isunknown(a)
  ) else $error("spsram: unknown address while enabled");

endmodule : spsram_2048x128

/* source/bank_cfg.sv */
// Config registers for macro enable mask, drop counter, init trigger and status
module bank_cfg #(
  parameter int NUM_MACROS = 2
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  cfg_wr,
  input  bank_pkg::cfg_addr_t   cfg_addr,
  input  bank_pkg::cfg_data_t   cfg_wdata,
  output bank_pkg::cfg_data_t   cfg_rdata,
  input  logic                  busy,
  input  logic                  drop,
  output logic [NUM_MACROS-1:0] macro_en,
  output logic                  init_start
);

  import bank_pkg::*;

  cfg_data_t drop_cnt;
  logic      wr_enable;
  logic      wr_drops;
  logic      wr_init;

  // Register write decode
  assign wr_enable = cfg_wr && (cfg_addr == CFG_ENABLE);
  assign wr_drops  = cfg_wr && (cfg_addr == CFG_DROPS);
  assign wr_init   = cfg_wr && (cfg_addr == CFG_INIT);

  // Enable mask, all macros on after reset
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      macro_en <= '1;
    end else if (wr_enable) begin
      macro_en <= cfg_wdata[NUM_MACROS-1:0];
    end
  end

  // Drop counter
  // Clear wins over a drop in the same cycle
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (wr_drops) begin
      drop_cnt <= '0;
    end else if (drop && (drop_cnt != '1)) begin
      // Saturate at all ones
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  // Init trigger, one-cycle pulse
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      init_start <= 1'b0;
    end else begin
      init_start <= wr_init && cfg_wdata[0];
    end
  end

  // Readback mux
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      CFG_ENABLE: cfg_rdata[NUM_MACROS-1:0] = macro_en;
      CFG_DROPS:  cfg_rdata = drop_cnt;
      CFG_INIT:   cfg_rdata[0] = busy;
      default:    cfg_rdata = '0;
    endcase
  end

endmodule : bank_cfg

/* source/bank_ctrl.sv */
// Access steering across macros, read return, drop detection and init FSM
module bank_ctrl #(
  parameter int NUM_MACROS = 2
) (
  input  logic                                   CLK,
  input  logic                                   rst_n,
  input  logic                                   rd,
  input  logic                                   wr,
  input  logic [sram_pkg::MACRO_ADDR_W+$clog2(NUM_MACROS)-1:0] addr,
  input  sram_pkg::sram_data_t                   wdata,
  output sram_pkg::sram_data_t                   rdata,
  output logic                                   rvalid,
  input  logic [NUM_MACROS-1:0]                  macro_en,
  input  logic                                   init_start,
  output logic                                   busy,
  output logic                                   drop,
  output logic [NUM_MACROS-1:0]                  cen_n,
  output logic                                   gwen_n,
  output sram_pkg::sram_data_t                   wen_n,
  output sram_pkg::sram_addr_t                   a,
  output sram_pkg::sram_data_t                   d,
  input  sram_pkg::sram_data_t [NUM_MACROS-1:0]  q
);

  import sram_pkg::*;
  import bank_pkg::*;

  // Macro select sits in the top address bits
  localparam int SEL_W   = $clog2(NUM_MACROS);
  localparam int BANK_AW = MACRO_ADDR_W + SEL_W;

  ctrl_state_t           state;
  ctrl_state_t           state_nxt;
  logic [BANK_AW-1:0]    init_addr;
  logic [BANK_AW-1:0]    cur_addr;
  logic [SEL_W-1:0]      req_sel;
  logic [SEL_W-1:0]      cur_sel;
  logic [SEL_W-1:0]      rd_sel_q;
  logic [NUM_MACROS-1:0] cur_oh;
  logic                  req;
  logic                  req_ok;
  logic                  active;

  assign busy = (state == INIT);

  // Init FSM
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: if (init_start) state_nxt = INIT;
      // Leave after the last bank address is written
      INIT: if (init_addr == '1) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      init_addr <= '0;
    end else begin
      state <= state_nxt;
      // Wraps back to zero on the last step
      if (busy) begin
        init_addr <= init_addr + 1'b1;
      end
    end
  end

  // Requester side decode
  assign req     = rd || wr;
  assign req_sel = addr[BANK_AW-1 -: SEL_W];
  // Served only when idle and the target macro is on
  assign req_ok  = !busy && macro_en[req_sel];

  // Init walk owns the macros while busy
  assign cur_addr = busy ? init_addr : addr;
  assign cur_sel  = cur_addr[BANK_AW-1 -: SEL_W];
  assign cur_oh   = NUM_MACROS'(1) << cur_sel;
  assign active   = busy || req;

  // Macro side controls
  // Disabled macros never see a chip enable, init skips them too
  assign cen_n  = ~({NUM_MACROS{active}} & cur_oh & macro_en);
  assign gwen_n = busy ? 1'b0 : !wr;
  // Whole-word mask follows the global write
  assign wen_n  = {DATA_W{gwen_n}};
  assign a      = cur_addr[MACRO_ADDR_W-1:0];
  assign d      = busy ? '0 : wdata;

  // Read return and drop pulse
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rvalid   <= 1'b0;
      drop     <= 1'b0;
      rd_sel_q <= '0;
    end else begin
      rvalid <= rd && req_ok;
      drop   <= req && !req_ok;
      if (rd && req_ok) begin
        rd_sel_q <= req_sel;
      end
    end
  end

  // Data comes from the macro picked one cycle earlier
  assign rdata = q[rd_sel_q];

  // Requester contract
  a_rd_wr_excl: assert property (
    @(posedge CLK) disable iff (!rst_n) !(rd && wr)
  ) else $error("bank_ctrl: rd and wr high together");

  // No read data can come out of an init cycle
  a_no_rvalid_after_busy: assert property (
    @(posedge CLK) disable iff (!rst_n) busy |=> !rvalid
  ) else $error("bank_ctrl: rvalid after a busy cycle");

endmodule : bank_ctrl

/* source/l2_data_bank.sv */
// Top level joining the config block, the access controller and the macros
module l2_data_bank #(
  parameter int NUM_MACROS = 2
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 rd,
  input  logic                 wr,
  input  logic [sram_pkg::MACRO_ADDR_W+$clog2(NUM_MACROS)-1:0] addr,
  input  sram_pkg::sram_data_t wdata,
  output sram_pkg::sram_data_t rdata,
  output logic                 rvalid,
  input  logic                 cfg_wr,
  input  bank_pkg::cfg_addr_t  cfg_addr,
  input  bank_pkg::cfg_data_t  cfg_wdata,
  output bank_pkg::cfg_data_t  cfg_rdata
);

  import sram_pkg::*;

  // Config to controller
  logic [NUM_MACROS-1:0] macro_en;
  logic                  init_start;
  logic                  busy;
  logic                  drop;

  // Controller to macros, shared except the chip enables
  logic [NUM_MACROS-1:0]       cen_n;
  logic                        gwen_n;
  sram_data_t                  wen_n;
  sram_addr_t                  a;
  sram_data_t                  d;
  sram_data_t [NUM_MACROS-1:0] q;

  bank_cfg #(
    .NUM_MACROS(NUM_MACROS)
  ) i_cfg (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .busy      (busy),
    .drop      (drop),
    .macro_en  (macro_en),
    .init_start(init_start)
  );

  bank_ctrl #(
    .NUM_MACROS(NUM_MACROS)
  ) i_ctrl (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .rd        (rd),
    .wr        (wr),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .macro_en  (macro_en),
    .init_start(init_start),
    .busy      (busy),
    .drop      (drop),
    .cen_n     (cen_n),
    .gwen_n    (gwen_n),
    .wen_n     (wen_n),
    .a         (a),
    .d         (d),
    .q         (q)
  );

  // One macro per select value
  for (genvar gi = 0; gi < NUM_MACROS; gi++) begin : g_macro
    spsram_2048x128 i_sram (
      .CLK   (CLK),
      .a     (a),
      .cen_n (cen_n[gi]),
      .gwen_n(gwen_n),
      .wen_n (wen_n),
      .d     (d),
      .q     (q[gi])
    );
  end

endmodule : l2_data_bank

/* testbench/tb_tests.svh */
// Bus tasks, reference memory and directed tests for the data bank
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// Expected contents of every bank word
sram_data_t ref_mem [BANK_WORDS];
// Addresses touched by the data test
logic [BANK_AW-1:0] written_q [$];

task automatic idle_cycles(input int n);
  repeat (n) @(posedge CLK);
  #1;
endtask

task automatic cfg_write(input cfg_addr_t ra, input cfg_data_t val);
  cfg_wr    = 1'b1;
  cfg_addr  = ra;
  cfg_wdata = val;
  @(posedge CLK);
  #1;
  cfg_wr = 1'b0;
endtask

// Combinational readback sampled one edge later
task automatic cfg_read(input cfg_addr_t ra, output cfg_data_t val);
  cfg_addr = ra;
  @(posedge CLK);
  #1;
  val = cfg_rdata;
endtask

task automatic cfg_expect(input cfg_addr_t ra, input cfg_data_t exp, input string msg);
  cfg_data_t val;
  cfg_read(ra, val);
  check_equal(val, exp, msg);
endtask

task automatic bus_write(input logic [BANK_AW-1:0] wa, input sram_data_t val);
  wr    = 1'b1;
  addr  = wa;
  wdata = val;
  @(posedge CLK);
  #1;
  wr = 1'b0;
  check_equal(rvalid, 1'b0, "no read return after a write");
endtask

// Data must come back on the very next edge
task automatic read_expect(input logic [BANK_AW-1:0] ra);
  rd   = 1'b1;
  addr = ra;
  @(posedge CLK);
  #1;
  rd = 1'b0;
  check_equal(rvalid, 1'b1, $sformatf("rvalid one cycle after rd at %h", ra));
  check_equal(rdata, ref_mem[ra], $sformatf("read data at %h", ra));
endtask

task automatic read_dropped(input logic [BANK_AW-1:0] ra);
  rd   = 1'b1;
  addr = ra;
  @(posedge CLK);
  #1;
  rd = 1'b0;
  check_equal(rvalid, 1'b0, $sformatf("no rvalid for dropped read at %h", ra));
endtask

// Busy should show within a few cycles of the trigger
task automatic run_init_start();
  cfg_data_t st;
  int        n;
  cfg_write(CFG_INIT, 16'h0001);
  n = 0;
  cfg_read(CFG_INIT, st);
  while (st[0] !== 1'b1 && n < 4) begin
    cfg_read(CFG_INIT, st);
    n++;
  end
  check_equal(st[0], 1'b1, "busy after init trigger");
endtask

task automatic wait_init_done();
  cfg_data_t st;
  int        n;
  n = 0;
  cfg_read(CFG_INIT, st);
  while (st[0] !== 1'b0 && n < INIT_CYCLES) begin
    cfg_read(CFG_INIT, st);
    n++;
  end
  check_equal(st[0], 1'b0, "busy cleared within the init budget");
endtask

task automatic clear_ref(input int first, input int last);
  for (int i = first; i <= last; i++) begin
    ref_mem[i] = '0;
  end
endtask

task automatic test_reset_state();
  // All macros on and nothing counted
  cfg_expect(CFG_ENABLE, cfg_data_t'((1 << NUM_MACROS) - 1), "enable mask after reset");
  cfg_expect(CFG_DROPS, '0, "drop count after reset");
  cfg_expect(CFG_INIT, '0, "busy after reset");
  repeat (4) begin
    check_equal(rvalid, 1'b0, "rvalid low after reset");
    idle_cycles(1);
  end
endtask

task automatic test_write_read();
  logic [BANK_AW-1:0] wa;
  sram_data_t         wd;
  for (int i = 0; i < 24; i++) begin
    wa = BANK_AW'(rand_bits(MACRO_ADDR_W));
    // Alternate halves so both macros see traffic
    wa[BANK_AW-1] = i[0];
    wd = rand_bits(DATA_W);
    bus_write(wa, wd);
    ref_mem[wa] = wd;
    written_q.push_back(wa);
  end
  // Back to back reads
  foreach (written_q[i]) begin
    read_expect(written_q[i]);
  end
  idle_cycles(1);
  check_equal(rvalid, 1'b0, "rvalid is a single pulse");
  // Read right behind a write to the same word
  for (int i = 0; i < 4; i++) begin
    wa = BANK_AW'(rand_bits(BANK_AW));
    wd = rand_bits(DATA_W);
    bus_write(wa, wd);
    ref_mem[wa] = wd;
    written_q.push_back(wa);
    read_expect(wa);
  end
endtask

task automatic test_init_clear();
  run_init_start();
  wait_init_done();
  clear_ref(0, BANK_WORDS - 1);
  foreach (written_q[i]) begin
    read_expect(written_q[i]);
  end
endtask

task automatic test_busy_drops();
  run_init_start();
  // Walk is already past the low words
  idle_cycles(8);
  for (int i = 0; i < 3; i++) begin
    bus_write(BANK_AW'(i), rand_bits(DATA_W));
    read_dropped(BANK_AW'(i));
  end
  wait_init_done();
  idle_cycles(2);
  // Nothing was dropped before this test
  cfg_expect(CFG_DROPS, 16'd6, "drops counted during init");
  // A write that slipped through would survive here
  for (int i = 0; i < 3; i++) begin
    read_expect(BANK_AW'(i));
  end
endtask

task automatic test_disabled_macro();
  logic [BANK_AW-1:0] up;
  logic [BANK_AW-1:0] lo;
  sram_data_t         wd;
  up = BANK_AW'(rand_bits(MACRO_ADDR_W));
  up[BANK_AW-1] = 1'b1;
  lo = BANK_AW'(rand_bits(MACRO_ADDR_W));
  lo[BANK_AW-1] = 1'b0;
  wd = rand_bits(DATA_W);
  bus_write(up, wd);
  ref_mem[up] = wd;
  wd = rand_bits(DATA_W);
  bus_write(lo, wd);
  ref_mem[lo] = wd;
  cfg_write(CFG_DROPS, '0);
  // Upper macro off
  cfg_write(CFG_ENABLE, 16'h0001);
  bus_write(up, ~ref_mem[up]);
  read_dropped(up);
  read_expect(lo);
  idle_cycles(2);
  cfg_expect(CFG_DROPS, 16'd2, "drops to the disabled macro");
  cfg_write(CFG_ENABLE, 16'h0003);
  read_expect(up);
  // Init skips the disabled half
  cfg_write(CFG_ENABLE, 16'h0001);
  run_init_start();
  wait_init_done();
  cfg_write(CFG_ENABLE, 16'h0003);
  clear_ref(0, BANK_WORDS / 2 - 1);
  read_expect(up);
  read_expect(lo);
endtask

task automatic test_drop_clear();
  // Two drops left from the disabled macro test
  cfg_expect(CFG_DROPS, 16'd2, "drop count before clear");
  // Any value clears
  cfg_write(CFG_DROPS, 16'h1234);
  cfg_expect(CFG_DROPS, '0, "drop count after clear");
endtask

`endif

/* testbench/tb_l2_data_bank.sv */
// Testbench top with clock, reset, DUT instance, watchdog, LFSR, check task and test order
module tb_l2_data_bank;
  timeunit 1ns;
  timeprecision 1ps;

  import sram_pkg::*;
  import bank_pkg::*;

  localparam int NUM_MACROS = 2;
  localparam int BANK_AW    = MACRO_ADDR_W + $clog2(NUM_MACROS);
  localparam int BANK_WORDS = 2 ** BANK_AW;
  localparam int CLK_PERIOD = 8;

  // Cycle budget, three init walks plus the short tests
  localparam int INIT_CYCLES     = 4100;
  localparam int OTHER_CYCLES    = 1000;
  localparam int WATCHDOG_CYCLES = 2 * (3 * INIT_CYCLES + OTHER_CYCLES);

  logic               CLK;
  logic               rst_n;
  logic               rd;
  logic               wr;
  logic [BANK_AW-1:0] addr;
  sram_data_t         wdata;
  sram_data_t         rdata;
  logic               rvalid;
  logic               cfg_wr;
  cfg_addr_t          cfg_addr;
  cfg_data_t          cfg_wdata;
  cfg_data_t          cfg_rdata;

  // Fibonacci LFSR state
  logic [31:0] lfsr = 32'hf748_a676;

  l2_data_bank #(
    .NUM_MACROS(NUM_MACROS)
  ) i_dut (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .cfg_wr   (cfg_wr),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  // One LFSR step, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // n random bits, right aligned
  function automatic logic [DATA_W-1:0] rand_bits(input int n);
    logic [DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[DATA_W-2:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic check_equal(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
      $display("sim failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    rst_n     = 1'b0;
    rd        = 1'b0;
    wr        = 1'b0;
    addr      = '0;
    wdata     = '0;
    cfg_wr    = 1'b0;
    cfg_addr  = CFG_ENABLE;
    cfg_wdata = '0;
    repeat (8) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_write_read();
    test_init_clear();
    test_busy_drops();
    test_disabled_macro();
    test_drop_clear();
    $display("sim passed");
    $finish;
  end

endmodule : tb_l2_data_bank

/* l2_data_bank.f */
+incdir+testbench
source/sram_pkg.sv
source/bank_pkg.sv
source/fpga_ram.sv
source/spsram_2048x128.sv
source/bank_cfg.sv
source/bank_ctrl.sv
source/l2_data_bank.sv
testbench/tb_l2_data_bank.sv

/* run_sim.sh */
#!/bin/sh
# Build the l2_data_bank testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f l2_data_bank.f --top-module tb_l2_data_bank -o tb_l2_data_bank &&
./obj_dir/tb_l2_data_bank | tee /dev/stderr | grep -q "^sim passed$" &&
echo "run_sim: PASS" || { echo "run_sim: FAIL"; exit 1; }
